/* Makefile */
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module basic_organ_tb -o basic_organ_sim
	./obj_dir/basic_organ_sim | tee $(SIM_LOG)
	@if grep -q "FAIL: see errors above" $(SIM_LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

/* bench/basic_organ_properties.sv */
`timescale 1ns/1ps

module basic_organ_properties (
  input logic               CLK_50M,
  input logic               reset,
  input logic [3:0]         sw,
  input organ_pkg::led_t    ledr,
  input logic               tone_out,
  input organ_pkg::sample_t audio_sample
);

  // ==============================
  // Output properties
  // ==============================

  // Exactly one LED lit
  led_one_hot: assert property (@(posedge CLK_50M) disable iff (reset) $onehot(ledr))
    else $error("ledr is not one-hot: %h", ledr);

  // Full-scale sample, high only while the tone is high
  sample_full_scale: assert property (@(posedge CLK_50M) disable iff (reset)
    (audio_sample == 8'h80) || ((audio_sample == 8'h7F) && tone_out))
    else $error("audio_sample out of range or high with tone low: %h", audio_sample);

  // Enable goes through two registers before it reaches the sample
  sample_gated: assert property (@(posedge CLK_50M) disable iff (reset)
    !$past(sw[0], 2) |-> (audio_sample == 8'h80))
    else $error("audio_sample not silent with enable low: %h", audio_sample);

endmodule

/* bench/basic_organ_tb.sv */
`timescale 1ns/1ps

module basic_organ_tb;

  localparam int act_none       = 0;
  localparam int act_up         = 1;
  localparam int act_down       = 2;
  localparam int act_reset      = 3;
  localparam int window_cycles  = 16;
  localparam int refresh_cycles = 8;
  localparam int num_tests      = 10;

  // Each row holds note, enable, key action, key windows and expected sampling count
  localparam int tests [0:num_tests-1][0:4] = '{
    '{0, 1, act_up,    3, 12799},
    '{1, 1, act_down,  5, 12299},
    '{2, 1, act_reset, 1, 12499},
    '{3, 1, act_up,    1, 12599},
    '{4, 0, act_none,  0, 12599},
    '{5, 1, act_down,  2, 12399},
    '{6, 1, act_up,    4, 12799},
    '{7, 1, act_reset, 1, 12499},
    '{2, 0, act_down,  1, 12399},
    '{7, 1, act_reset, 1, 12499}
  };

  // Reference half periods at 50 MHz from Do 523 Hz up to Do 1046 Hz
  localparam int ref_half [0:7] = '{
    'hBAB7, 'hA65B, 'h942E, 'h8BE7, 'h7CB6, 'h6EF7, 'h62EF, 'h5D5B
  };

  // Active-low seven-segment digits 0 to F with segment a in bit 0
  localparam logic [6:0] glyph [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  // Bouncing LED order starting from reset
  localparam logic [7:0] led_seq [0:16] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h40,
    8'h20, 8'h10, 8'h08, 8'h04, 8'h02, 8'h01, 8'h02, 8'h04
  };

  logic               CLK_50M;
  logic               reset;
  logic [3:0]         sw;
  logic [2:0]         key;
  organ_pkg::led_t    ledr;
  logic               tone_out;
  organ_pkg::sample_t audio_sample;
  organ_pkg::seg_t    hex0;
  organ_pkg::seg_t    hex1;
  organ_pkg::seg_t    hex2;
  organ_pkg::seg_t    hex3;
  organ_pkg::seg_t    hex4;
  organ_pkg::seg_t    hex5;

  int error_count;
  int check_count;
  int test_count;

  basic_organ #(
    .note_shift          (8),
    .led_tick_cycles     (20),
    .event_tick_cycles   (window_cycles),
    .refresh_tick_cycles (refresh_cycles)
  ) basic_organ_i (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sw           (sw),
    .key          (key),
    .ledr         (ledr),
    .tone_out     (tone_out),
    .audio_sample (audio_sample),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  bind basic_organ basic_organ_properties properties_i (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sw           (sw),
    .ledr         (ledr),
    .tone_out     (tone_out),
    .audio_sample (audio_sample)
  );

  initial
    CLK_50M = 1'b0;

  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Helpers
  // ==============================

  // Lands 2 ns after a rising edge, where inputs change and outputs are settled
  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge CLK_50M);
      #2;
    end
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Six digits of a value as the display should show them
  function automatic logic [41:0] display_for(input int value);
    logic [41:0] segs;
    logic [3:0]  nib;
    segs = '0;
    for (int d = 0; d < 6; d++)
    begin
      nib = 4'(value >> (4 * d));
      segs[7*d +: 7] = glyph[nib];
    end
    return segs;
  endfunction

  task automatic check_display(input int value, input string what);
    check_value(64'({hex5, hex4, hex3, hex2, hex1, hex0}), 64'(display_for(value)), what);
  endtask

  // Syncs to a toggle, then times each following half period
  task automatic measure_tone(input int expected_half, input logic enable, input int halves);
    logic last;
    int   cycles;
    last = tone_out;
    do
      wait_cycles(1);
    while (tone_out == last);
    for (int h = 0; h < halves; h++)
    begin
      cycles = 0;
      last = tone_out;
      do
      begin
        wait_cycles(1);
        cycles++;
        check_value(64'($unsigned(audio_sample)), (enable && tone_out) ? 64'h7F : 64'h80,
                    "audio sample against tone");
      end
      while (tone_out == last);
      check_value(64'(cycles), 64'(expected_half), "cycles between tone toggles");
    end
  endtask

  task automatic press_key(input int action, input int windows);
    int         hold;
    logic [2:0] pressed;
    if (action != act_none)
    begin
      case (action)
        act_up:   pressed = 3'b110;
        act_down: pressed = 3'b101;
        default:  pressed = 3'b011;
      endcase
      // Up and down cover an exact number of windows while reset may linger
      if (action == act_reset)
        hold = window_cycles + int'($urandom % 16);
      else
      begin
        wait_cycles(int'($urandom % 16));
        hold = window_cycles * windows;
      end
      key = pressed;
      wait_cycles(hold);
      key = 3'b111;
    end
  endtask

  function automatic int budget_cycles();
    int total;
    total = 1000;
    for (int i = 0; i < num_tests; i++)
      total += 8 * (ref_half[tests[i][0]] >> 8) + window_cycles * (tests[i][3] + 4) + 64;
    return total;
  endfunction

  // ==============================
  // Watchdog
  // ==============================

  initial
  begin
    int limit;
    limit = budget_cycles();
    repeat (limit) @(posedge CLK_50M);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

  // ==============================
  // Stimulus
  // ==============================

  initial
  begin
    int errors_before;
    reset = 1'b1;
    sw = 4'b0000;
    key = 3'b111;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    void'($urandom(32'h0aca417b));
    wait_cycles(4);
    reset = 1'b0;

    // Values straight out of reset, then the first display refresh
    check_value(64'(ledr), 64'h01, "ledr after reset");
    check_value(64'(tone_out), 64'h0, "tone_out after reset");
    check_value(64'($unsigned(audio_sample)), 64'h80, "audio sample after reset");
    check_display(0, "display before first refresh");
    wait_cycles(refresh_cycles + 1);
    check_display(12499, "display after first refresh");
    test_count++;
    $display("test reset: %0d errors so far", error_count);

    // One sample right after each LED tick
    errors_before = error_count;
    do
      wait_cycles(1);
    while (ledr == 8'h01);
    check_value(64'(ledr), 64'(led_seq[1]), "ledr after first tick");
    for (int k = 2; k < 17; k++)
    begin
      wait_cycles(20);
      check_value(64'(ledr), 64'(led_seq[k]), $sformatf("ledr at step %0d", k));
    end
    test_count++;
    $display("test leds: %s", (error_count == errors_before) ? "ok" : "errors");

    for (int i = 0; i < num_tests; i++)
    begin
      errors_before = error_count;
      sw = {3'(tests[i][0]), tests[i][1] != 0};
      wait_cycles(3);
      measure_tone(ref_half[tests[i][0]] >> 8, tests[i][1] != 0, (tests[i][1] != 0) ? 2 : 6);
      press_key(tests[i][2], tests[i][3]);
      wait_cycles(window_cycles);
      check_display(tests[i][4], $sformatf("display count in test %0d", i));
      test_count++;
      $display("test %0d: note %0d enable %0d key action %0d x%0d count %0d: %s",
               i, tests[i][0], tests[i][1], tests[i][2], tests[i][3], tests[i][4],
               (error_count == errors_before) ? "ok" : "errors");
    end

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sources.f */
src/organ_pkg.sv
src/tone_generator.sv
src/led_slider.sv
src/speed_control.sv
src/hex_display.sv
src/basic_organ.sv
bench/basic_organ_properties.sv
bench/basic_organ_tb.sv

/* src/basic_organ.sv */
`timescale 1ns/1ps

module basic_organ #(
  parameter int note_shift          = 0,
  parameter int led_tick_cycles     = 50_000_000,
  parameter int event_tick_cycles   = 5_000_000,
  parameter int refresh_tick_cycles = 25_000_000
) (
  input  logic               CLK_50M,
  input  logic               reset,
  input  logic [3:0]         sw,
  input  logic [2:0]         key,
  output organ_pkg::led_t    ledr,
  output logic               tone_out,
  output organ_pkg::sample_t audio_sample,
  output organ_pkg::seg_t    hex0,
  output organ_pkg::seg_t    hex1,
  output organ_pkg::seg_t    hex2,
  output organ_pkg::seg_t    hex3,
  output organ_pkg::seg_t    hex4,
  output organ_pkg::seg_t    hex5
);

  organ_pkg::count_t sampling_count;

  // sw[0] gates the tone, sw[3:1] picks the note
  tone_generator #(
    .note_shift(note_shift)
  ) tone_generator_i (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .enable       (sw[0]),
    .note         (sw[3:1]),
    .tone_out     (tone_out),
    .audio_sample (audio_sample)
  );

  led_slider #(
    .led_tick_cycles(led_tick_cycles)
  ) led_slider_i (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .ledr    (ledr)
  );

  speed_control #(
    .event_tick_cycles(event_tick_cycles)
  ) speed_control_i (
    .CLK_50M        (CLK_50M),
    .reset          (reset),
    .key            (key),
    .sampling_count (sampling_count)
  );

  hex_display #(
    .refresh_tick_cycles(refresh_tick_cycles)
  ) hex_display_i (
    .CLK_50M        (CLK_50M),
    .reset          (reset),
    .sampling_count (sampling_count),
    .hex0           (hex0),
    .hex1           (hex1),
    .hex2           (hex2),
    .hex3           (hex3),
    .hex4           (hex4),
    .hex5           (hex5)
  );

endmodule

/* src/hex_display.sv */
`timescale 1ns/1ps

module hex_display #(
  parameter int refresh_tick_cycles = 25_000_000
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  organ_pkg::count_t sampling_count,
  output organ_pkg::seg_t   hex0,
  output organ_pkg::seg_t   hex1,
  output organ_pkg::seg_t   hex2,
  output organ_pkg::seg_t   hex3,
  output organ_pkg::seg_t   hex4,
  output organ_pkg::seg_t   hex5
);

  localparam int refresh_w = $clog2(refresh_tick_cycles + 1);

  logic [refresh_w-1:0] refresh_count;
  logic                 refresh;
  logic [23:0]          shown;
  organ_pkg::seg_t      digit [0:5];

  // 2 Hz refresh keeps the digits readable
  assign refresh = (refresh_count == refresh_w'(refresh_tick_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || refresh)
      refresh_count <= '0;
    else
      refresh_count <= refresh_count + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      shown <= '0;
    else if (refresh)
      shown <= 24'(sampling_count);
  end

  // One glyph lookup per nibble
  for (genvar i = 0; i < 6; i++)
  begin : g_digit
    assign digit[i] = organ_pkg::hex_glyph[shown[4*i +: 4]];
  end

  assign hex0 = digit[0];
  assign hex1 = digit[1];
  assign hex2 = digit[2];
  assign hex3 = digit[3];
  assign hex4 = digit[4];
  assign hex5 = digit[5];

endmodule

/* src/led_slider.sv */
`timescale 1ns/1ps

module led_slider #(
  parameter int led_tick_cycles = 50_000_000
) (
  input  logic            CLK_50M,
  input  logic            reset,
  output organ_pkg::led_t ledr
);

  localparam int tick_w = $clog2(led_tick_cycles + 1);

  logic [tick_w-1:0]     tick_count;
  logic                  tick;
  organ_pkg::slide_dir_t dir;

  // 1 Hz tick on the real board
  assign tick = (tick_count == tick_w'(led_tick_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || tick)
      tick_count <= '0;
    else
      tick_count <= tick_count + 1'b1;
  end

  // Direction FSM, turns around at either end of the bank
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      ledr <= 8'h01;
      dir  <= organ_pkg::dir_left;
    end
    else if (tick)
    begin
      case (dir)
        organ_pkg::dir_left:
        begin
          if (ledr[7])
          begin
            ledr <= ledr >> 1;
            dir  <= organ_pkg::dir_right;
          end
          else
            ledr <= ledr << 1;
        end
        default:
        begin
          if (ledr[0])
          begin
            ledr <= ledr << 1;
            dir  <= organ_pkg::dir_left;
          end
          else
            ledr <= ledr >> 1;
        end
      endcase
    end
  end

endmodule

/* src/organ_pkg.sv */
package organ_pkg;

  // ==============================
  // Widths with a meaning
  // ==============================

  typedef logic [2:0]         note_sel_t;
  typedef logic [31:0]        half_period_t;
  typedef logic signed [7:0]  sample_t;
  typedef logic [7:0]         led_t;
  typedef logic signed [15:0] speed_t;
  typedef logic [15:0]        count_t;
  typedef logic [6:0]         seg_t;

  typedef enum logic {
    dir_left,
    dir_right
  } slide_dir_t;

  // Half tone periods in CLK_50M cycles, Do 523 Hz up to Do 1046 Hz
  localparam half_period_t note_half_period [0:7] = '{
    32'hBAB7, 32'hA65B, 32'h942E, 32'h8BE7,
    32'h7CB6, 32'h6EF7, 32'h62EF, 32'h5D5B
  };

  // Sampling count and step of the speed keys
  localparam count_t default_sampling_count = 16'd12499;
  localparam speed_t speed_step             = 16'sd100;

  // Active-low segments, bit 0 is segment a
  localparam seg_t hex_glyph [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

/* src/speed_control.sv */
`timescale 1ns/1ps

module speed_control #(
  parameter int event_tick_cycles = 5_000_000
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic [2:0]        key,
  output organ_pkg::count_t sampling_count
);

  localparam int win_w = $clog2(event_tick_cycles + 1);

  logic [2:0]         key_meta;
  logic [2:0]         key_sync;
  logic               up_held;
  logic               down_held;
  logic               reset_held;
  logic [win_w-1:0]   win_count;
  logic               window;
  organ_pkg::speed_t  speed_offset;

  // ==============================
  // Key synchronizers
  // ==============================

  // Keys idle high, so the flops come out of reset released
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  assign up_held    = ~key_sync[0];
  assign down_held  = ~key_sync[1];
  assign reset_held = ~key_sync[2];

  // ==============================
  // Rate limit and offset
  // ==============================

  // One window every event_tick_cycles, 10 per second on the board
  assign window = (win_count == win_w'(event_tick_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || window)
      win_count <= '0;
    else
      win_count <= win_count + 1'b1;
  end

  // Reset key wins over everything, then up over down
  always_ff @(posedge CLK_50M)
  begin
    if (reset || reset_held)
      speed_offset <= '0;
    else if (window && up_held)
      speed_offset <= speed_offset + organ_pkg::speed_step;
    else if (window && down_held)
      speed_offset <= speed_offset - organ_pkg::speed_step;
  end

  // Count follows the offset one cycle later
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sampling_count <= organ_pkg::default_sampling_count;
    else
      sampling_count <= organ_pkg::default_sampling_count
                        + organ_pkg::count_t'(speed_offset);
  end

endmodule

/* src/tone_generator.sv */
`timescale 1ns/1ps

module tone_generator #(
  parameter int note_shift = 0
) (
  input  logic                 CLK_50M,
  input  logic                 reset,
  input  logic                 enable,
  input  organ_pkg::note_sel_t note,
  output logic                 tone_out,
  output organ_pkg::sample_t   audio_sample
);

  localparam organ_pkg::sample_t sample_high = 8'h7F;
  localparam organ_pkg::sample_t sample_low  = 8'h80;

  organ_pkg::note_sel_t    note_q;
  logic                    enable_q;
  organ_pkg::half_period_t half_limit;
  organ_pkg::half_period_t count;
  logic                    wrap;
  logic                    tone_next;

  // Switches registered once
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      note_q   <= '0;
      enable_q <= 1'b0;
    end
    else
    begin
      note_q   <= note;
      enable_q <= enable;
    end
  end

  assign half_limit = organ_pkg::note_half_period[note_q] >> note_shift;
  assign wrap       = (count >= half_limit - 1'b1);
  assign tone_next  = wrap ? ~tone_out : tone_out;

  // Half-period counter, restarts on a note change
  always_ff @(posedge CLK_50M)
  begin
    if (reset || wrap || (note != note_q))
      count <= '0;
    else
      count <= count + 1'b1;
  end

  // Square wave and its signed sample move together
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tone_out     <= 1'b0;
      audio_sample <= sample_low;
    end
    else
    begin
      tone_out     <= tone_next;
      audio_sample <= (enable_q && tone_next) ? sample_high : sample_low;
    end
  end

endmodule
